//--- common/cpuPkg.sv
`default_nettype none

package cpuPkg;

    // Lanes per decode bundle
    localparam int MACHINE_WIDTH = 2;

    // Architectural and physical register file sizes
    localparam int AREG_COUNT = 32;
    localparam int PREG_COUNT = 64;

    typedef logic [4:0]  aregAddr_t;
    typedef logic [5:0]  pregAddr_t;

    // Opaque control bits, decoded further down the pipe
    typedef logic [7:0]  ctl_t;

    typedef logic [15:0] imm_t;

    // Return address of the instruction (pc + 8)
    typedef logic [31:0] addr_t;

    // One decoded instruction as delivered by the decode stage
    typedef struct packed {
        logic      valid;
        aregAddr_t src1;
        aregAddr_t src2;
        aregAddr_t dst;
        ctl_t      ctl;
        imm_t      imm;
        addr_t     pcplus8;
        logic      exception;
    } decodedInstr_t;

endpackage

`default_nettype wire

//--- common/renamePkg.sv
`default_nettype none

package renamePkg;

    // Physical registers not covered by the initial identity map
    localparam int FREE_COUNT = cpuPkg::PREG_COUNT - cpuPkg::AREG_COUNT;

    // Table reads per lane: src1, src2 and the old dst mapping
    localparam int READ_PER_LANE = 3;
    localparam int READ_PORTS = READ_PER_LANE * cpuPkg::MACHINE_WIDTH;

    // Free list occupancy, 0 to FREE_COUNT inclusive
    typedef logic [5:0] freeCount_t;

    // Index into the free list ring
    typedef logic [4:0] freePtr_t;

    // Number of lanes doing something in one cycle, 0 to MACHINE_WIDTH
    typedef logic [$clog2(cpuPkg::MACHINE_WIDTH + 1)-1:0] laneCount_t;

    typedef struct packed {
        logic              valid;
        cpuPkg::pregAddr_t psrc1;
        cpuPkg::pregAddr_t psrc2;
        cpuPkg::pregAddr_t pdst;
        cpuPkg::pregAddr_t oldPdst;
        cpuPkg::aregAddr_t src1;
        cpuPkg::aregAddr_t src2;
        cpuPkg::aregAddr_t dst;
        cpuPkg::ctl_t      ctl;
        cpuPkg::imm_t      imm;
        cpuPkg::addr_t     pcplus8;
        logic              exception;
    } renamedInstr_t;

    typedef struct packed {
        logic              valid;
        cpuPkg::pregAddr_t preg;
    } release_t;

    typedef cpuPkg::decodedInstr_t [cpuPkg::MACHINE_WIDTH-1:0] decodeBundle_t;
    typedef renamedInstr_t [cpuPkg::MACHINE_WIDTH-1:0] renamedBundle_t;
    typedef release_t [cpuPkg::MACHINE_WIDTH-1:0] releaseBundle_t;

endpackage

`default_nettype wire

//--- hw/renameUnit.sv
`timescale 1ns/10ps
`default_nettype none

// Register rename subsystem for the two-wide core
module renameUnit (
    input  logic                      clk,
    input  logic                      reset,
    input  renamePkg::decodeBundle_t  inBundle,
    input  renamePkg::releaseBundle_t releases,
    output renamePkg::renamedBundle_t outBundle,
    output logic                      stall
);

    renameStage u_renameStage (
        .clk       (clk),
        .reset     (reset),
        .inBundle  (inBundle),
        .releases  (releases),
        .outBundle (outBundle),
        .stall     (stall)
    );

endmodule

`default_nettype wire

//--- rename/freeList.sv
`timescale 1ns/10ps
`default_nettype none

module freeList (
    input  logic                                            clk,
    input  logic                                            reset,
    input  renamePkg::laneCount_t                           popCount,
    output cpuPkg::pregAddr_t [cpuPkg::MACHINE_WIDTH-1:0]   headPregs,
    input  renamePkg::releaseBundle_t                       releases,
    output renamePkg::freeCount_t                           count
);

    cpuPkg::pregAddr_t mem [renamePkg::FREE_COUNT];

    renamePkg::freePtr_t head;
    renamePkg::freePtr_t tail;

    // Valid releases packed down to the low lanes
    renamePkg::laneCount_t pushCount;
    cpuPkg::pregAddr_t [cpuPkg::MACHINE_WIDTH-1:0] pushPregs;

    // Oldest free entries, visible before the pop
    always_comb begin
        for (int i = 0; i < cpuPkg::MACHINE_WIDTH; i++) begin
            headPregs[i] = mem[head + renamePkg::freePtr_t'(i)];
        end
    end

    always_comb begin
        pushCount = '0;
        pushPregs = '0;
        for (int i = 0; i < cpuPkg::MACHINE_WIDTH; i++) begin
            if (releases[i].valid) begin
                pushPregs[pushCount] = releases[i].preg;
                pushCount = pushCount + 1'b1;
            end
        end
    end

    // Ring pointers and occupancy
    always_ff @(posedge clk) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
            count <= renamePkg::freeCount_t'(renamePkg::FREE_COUNT);
        end else begin
            head <= head + renamePkg::freePtr_t'(popCount);
            tail <= tail + renamePkg::freePtr_t'(pushCount);
            count <= count + renamePkg::freeCount_t'(pushCount)
                - renamePkg::freeCount_t'(popCount);
        end
    end

    // Starts out holding the registers above the identity range, ascending
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int e = 0; e < renamePkg::FREE_COUNT; e++) begin
                mem[e] <= cpuPkg::pregAddr_t'(cpuPkg::AREG_COUNT + e);
            end
        end else begin
            for (int i = 0; i < cpuPkg::MACHINE_WIDTH; i++) begin
                if (i < pushCount) begin
                    mem[tail + renamePkg::freePtr_t'(i)] <= pushPregs[i];
                end
            end
        end
    end

    // The stall logic upstream must keep pops within what is present
    popWithinCount: assert property (
        @(posedge clk) disable iff (reset)
        renamePkg::freeCount_t'(popCount) <= count
    ) else $error("free list pop of %0d with count %0d", popCount, count);

    // Releases must only return registers that were handed out
    countBounded: assert property (
        @(posedge clk) disable iff (reset)
        count <= renamePkg::freeCount_t'(renamePkg::FREE_COUNT)
    ) else $error("free list count %0d over capacity", count);

endmodule

`default_nettype wire

//--- rename/rawCheck.sv
`timescale 1ns/10ps
`default_nettype none

module rawCheck (
    input  cpuPkg::aregAddr_t [cpuPkg::MACHINE_WIDTH-1:0] src1,
    input  cpuPkg::aregAddr_t [cpuPkg::MACHINE_WIDTH-1:0] src2,
    input  cpuPkg::aregAddr_t [cpuPkg::MACHINE_WIDTH-1:0] dst,
    input  logic              [cpuPkg::MACHINE_WIDTH-1:0] laneWrites,
    input  cpuPkg::pregAddr_t [cpuPkg::MACHINE_WIDTH-1:0] psrc1Table,
    input  cpuPkg::pregAddr_t [cpuPkg::MACHINE_WIDTH-1:0] psrc2Table,
    input  cpuPkg::pregAddr_t [cpuPkg::MACHINE_WIDTH-1:0] oldPdstTable,
    input  cpuPkg::pregAddr_t [cpuPkg::MACHINE_WIDTH-1:0] pdstNew,
    output cpuPkg::pregAddr_t [cpuPkg::MACHINE_WIDTH-1:0] psrc1,
    output cpuPkg::pregAddr_t [cpuPkg::MACHINE_WIDTH-1:0] psrc2,
    output cpuPkg::pregAddr_t [cpuPkg::MACHINE_WIDTH-1:0] oldPdst
);

    // Start from the table view, then let every older writer override it.
    // Older lanes are scanned oldest first so the youngest older writer wins
    always_comb begin
        for (int i = 0; i < cpuPkg::MACHINE_WIDTH; i++) begin
            psrc1[i] = psrc1Table[i];
            psrc2[i] = psrc2Table[i];
            oldPdst[i] = oldPdstTable[i];

            for (int j = 0; j < i; j++) begin
                // laneWrites already excludes dst 0, so r0 is never forwarded
                if (laneWrites[j] && (src1[i] == dst[j])) begin
                    psrc1[i] = pdstNew[j];
                end
                if (laneWrites[j] && (src2[i] == dst[j])) begin
                    psrc2[i] = pdstNew[j];
                end
                if (laneWrites[j] && (dst[i] == dst[j])) begin
                    oldPdst[i] = pdstNew[j];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rename/renameMapTable.sv
`timescale 1ns/10ps
`default_nettype none

module renameMapTable (
    input  logic                                           clk,
    input  logic                                           reset,
    input  cpuPkg::aregAddr_t [renamePkg::READ_PORTS-1:0]    readAddr,
    output cpuPkg::pregAddr_t [renamePkg::READ_PORTS-1:0]    readData,
    input  logic              [cpuPkg::MACHINE_WIDTH-1:0]    writeEn,
    input  cpuPkg::aregAddr_t [cpuPkg::MACHINE_WIDTH-1:0]    writeAddr,
    input  cpuPkg::pregAddr_t [cpuPkg::MACHINE_WIDTH-1:0]    writeData
);

    // Architectural to physical map
    cpuPkg::pregAddr_t mapTable [cpuPkg::AREG_COUNT];

    // Asynchronous reads, one group of three per lane
    always_comb begin
        for (int k = 0; k < renamePkg::READ_PORTS; k++) begin
            readData[k] = mapTable[readAddr[k]];
        end
    end

    // Reset restores the identity map.
    // Lanes are applied in order, so the younger lane wins on a collision
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int a = 0; a < cpuPkg::AREG_COUNT; a++) begin
                mapTable[a] <= cpuPkg::pregAddr_t'(a);
            end
        end else begin
            for (int i = 0; i < cpuPkg::MACHINE_WIDTH; i++) begin
                if (writeEn[i]) begin
                    mapTable[writeAddr[i]] <= writeData[i];
                end
            end
        end
    end

    // The stage filters dst 0 so r0 keeps its identity mapping
    for (genvar i = 0; i < cpuPkg::MACHINE_WIDTH; i++) begin : gWriteCheck
        noWriteToZero: assert property (
            @(posedge clk) disable iff (reset)
            writeEn[i] |-> (writeAddr[i] != '0)
        ) else $error("map table write to r0 on lane %0d", i);
    end

endmodule

`default_nettype wire

//--- rename/renameStage.sv
`timescale 1ns/10ps
`default_nettype none

module renameStage (
    input  logic                      clk,
    input  logic                      reset,
    input  renamePkg::decodeBundle_t  inBundle,
    input  renamePkg::releaseBundle_t releases,
    output renamePkg::renamedBundle_t outBundle,
    output logic                      stall
);

    localparam int LANES = cpuPkg::MACHINE_WIDTH;

    cpuPkg::aregAddr_t [LANES-1:0] src1;
    cpuPkg::aregAddr_t [LANES-1:0] src2;
    cpuPkg::aregAddr_t [LANES-1:0] dst;
    logic              [LANES-1:0] laneWrites;
    logic              [LANES-1:0] writeEn;

    cpuPkg::aregAddr_t [renamePkg::READ_PORTS-1:0] readAddr;
    cpuPkg::pregAddr_t [renamePkg::READ_PORTS-1:0] readData;
    cpuPkg::pregAddr_t [LANES-1:0] psrc1Table;
    cpuPkg::pregAddr_t [LANES-1:0] psrc2Table;
    cpuPkg::pregAddr_t [LANES-1:0] oldPdstTable;
    cpuPkg::pregAddr_t [LANES-1:0] psrc1;
    cpuPkg::pregAddr_t [LANES-1:0] psrc2;
    cpuPkg::pregAddr_t [LANES-1:0] oldPdst;
    cpuPkg::pregAddr_t [LANES-1:0] headPregs;
    cpuPkg::pregAddr_t [LANES-1:0] pdstNew;

    renamePkg::laneCount_t allocCount;
    renamePkg::laneCount_t popCount;
    renamePkg::freeCount_t freeCount;
    logic                  anyValid;

    renamePkg::renamedBundle_t nextBundle;
    renamePkg::renamedBundle_t outPayload;
    logic [LANES-1:0]          outValid;

    // Lane decode and table read addresses
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            src1[i] = inBundle[i].src1;
            src2[i] = inBundle[i].src2;
            dst[i] = inBundle[i].dst;
            laneWrites[i] = inBundle[i].valid && (inBundle[i].dst != '0);
            readAddr[renamePkg::READ_PER_LANE*i] = inBundle[i].src1;
            readAddr[renamePkg::READ_PER_LANE*i + 1] = inBundle[i].src2;
            readAddr[renamePkg::READ_PER_LANE*i + 2] = inBundle[i].dst;
            psrc1Table[i] = readData[renamePkg::READ_PER_LANE*i];
            psrc2Table[i] = readData[renamePkg::READ_PER_LANE*i + 1];
            oldPdstTable[i] = readData[renamePkg::READ_PER_LANE*i + 2];
        end
    end

    // Allocating lanes take head entries in lane order
    always_comb begin
        allocCount = '0;
        anyValid = 1'b0;
        for (int i = 0; i < LANES; i++) begin
            anyValid = anyValid | inBundle[i].valid;
            pdstNew[i] = '0;
            if (laneWrites[i]) begin
                pdstNew[i] = headPregs[allocCount];
                allocCount = allocCount + 1'b1;
            end
        end
    end

    assign stall = anyValid && (freeCount < renamePkg::freeCount_t'(allocCount));
    assign popCount = stall ? '0 : allocCount;
    assign writeEn = stall ? '0 : laneWrites;

    renameMapTable u_renameMapTable (
        .clk       (clk),
        .reset     (reset),
        .readAddr  (readAddr),
        .readData  (readData),
        .writeEn   (writeEn),
        .writeAddr (dst),
        .writeData (pdstNew)
    );

    freeList u_freeList (
        .clk       (clk),
        .reset     (reset),
        .popCount  (popCount),
        .headPregs (headPregs),
        .releases  (releases),
        .count     (freeCount)
    );

    rawCheck u_rawCheck (
        .src1         (src1),
        .src2         (src2),
        .dst          (dst),
        .laneWrites   (laneWrites),
        .psrc1Table   (psrc1Table),
        .psrc2Table   (psrc2Table),
        .oldPdstTable (oldPdstTable),
        .pdstNew      (pdstNew),
        .psrc1        (psrc1),
        .psrc2        (psrc2),
        .oldPdst      (oldPdst)
    );

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            nextBundle[i].valid = inBundle[i].valid && !stall;
            nextBundle[i].psrc1 = psrc1[i];
            nextBundle[i].psrc2 = psrc2[i];
            nextBundle[i].pdst = pdstNew[i];
            nextBundle[i].oldPdst = oldPdst[i];
            nextBundle[i].src1 = inBundle[i].src1;
            nextBundle[i].src2 = inBundle[i].src2;
            nextBundle[i].dst = inBundle[i].dst;
            nextBundle[i].ctl = inBundle[i].ctl;
            nextBundle[i].imm = inBundle[i].imm;
            nextBundle[i].pcplus8 = inBundle[i].pcplus8;
            nextBundle[i].exception = inBundle[i].exception;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            outValid <= '0;
        end else begin
            for (int i = 0; i < LANES; i++) begin
                outValid[i] <= nextBundle[i].valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        outPayload <= nextBundle;
    end

    // Valid bits come from the reset-cleared vector
    always_comb begin
        outBundle = outPayload;
        for (int i = 0; i < LANES; i++) begin
            outBundle[i].valid = outValid[i];
        end
    end

    stallBubble: assert property (
        @(posedge clk) disable iff (reset)
        stall |=> (outValid == '0)
    ) else $error("renamed lane valid after a stall cycle");

endmodule

`default_nettype wire

//--- renameUnit.f
common/cpuPkg.sv
common/renamePkg.sv
rename/rawCheck.sv
rename/renameMapTable.sv
rename/freeList.sv
rename/renameStage.sv
hw/renameUnit.sv
tb/renameUnitTb.sv

//--- run.sh
#!/bin/sh
# Build and run the rename unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module renameUnitTb -f renameUnit.f -o VrenameUnitTb \
    && ./obj_dir/VrenameUnitTb | tee /dev/stderr | grep -qx '>>> PASS' \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }

//--- tb/renameUnitTb.sv
`timescale 1ns/10ps
`default_nettype none

module renameUnitTb;

    localparam int SEED = 93129;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_CYCLES = 2000;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_CYCLES + 100;
    localparam int PHASE_CYCLES = 250;

    logic                      clk;
    logic                      reset;
    renamePkg::decodeBundle_t  inBundle;
    renamePkg::releaseBundle_t releases;
    renamePkg::renamedBundle_t outBundle;
    logic                      stall;

    // Reference architectural map, free FIFO and registers awaiting release
    cpuPkg::pregAddr_t modelMap [cpuPkg::AREG_COUNT];
    cpuPkg::pregAddr_t freeQ [$];
    cpuPkg::pregAddr_t pool [$];

    renamePkg::decodeBundle_t  curBundle;
    renamePkg::releaseBundle_t curReleases;
    renamePkg::renamedBundle_t expOut;
    renamePkg::renamedBundle_t nextOut;
    logic                      expStall;
    logic                      heldStall;
    int                        stallCount;
    int                        cycleCount;
    int unsigned               seedDummy;

    renameUnit u_renameUnit (
        .clk       (clk),
        .reset     (reset),
        .inBundle  (inBundle),
        .releases  (releases),
        .outBundle (outBundle),
        .stall     (stall)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic failRun(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "renameUnit testbench stopped");
    endtask

    task automatic checkBundle(input renamePkg::renamedBundle_t got,
                               input renamePkg::renamedBundle_t expected);
        for (int i = 0; i < cpuPkg::MACHINE_WIDTH; i++) begin
            if (got[i].valid !== expected[i].valid) begin
                failRun($sformatf("ERROR: outBundle[%0d].valid got %h expected %h",
                                  i, got[i].valid, expected[i].valid));
            end else if (expected[i].valid && (got[i] !== expected[i])) begin
                failRun($sformatf("ERROR: outBundle[%0d] got %h expected %h",
                                  i, got[i], expected[i]));
            end
        end
    endtask

    task automatic checkStall(input logic got, input logic expected);
        if (got !== expected) begin
            failRun($sformatf("ERROR: stall got %h expected %h", got, expected));
        end
    endtask

    // Small register numbers are favoured so that lanes collide often
    function automatic cpuPkg::aregAddr_t randomAreg();
        int unsigned pick;
        pick = $urandom % 8;
        if (pick == 0) begin
            return '0;
        end else if (pick < 5) begin
            return cpuPkg::aregAddr_t'(1 + $urandom % 3);
        end
        return cpuPkg::aregAddr_t'($urandom % cpuPkg::AREG_COUNT);
    endfunction

    task automatic makeBundle(output renamePkg::decodeBundle_t b);
        for (int i = 0; i < cpuPkg::MACHINE_WIDTH; i++) begin
            b[i].valid = ($urandom % 4) != 0;
            b[i].src1 = randomAreg();
            b[i].src2 = randomAreg();
            b[i].dst = randomAreg();
            b[i].ctl = cpuPkg::ctl_t'($urandom);
            b[i].imm = cpuPkg::imm_t'($urandom);
            b[i].pcplus8 = cpuPkg::addr_t'($urandom);
            b[i].exception = ($urandom % 16) == 0;
        end
    endtask

    // The zero-rate phase drains the free list
    function automatic int releaseRate(input int cyc);
        case ((cyc / PHASE_CYCLES) % 4)
            0: return 70;
            1: return 0;
            2: return 40;
            default: return 10;
        endcase
    endfunction

    task automatic makeReleases(input int rate, output renamePkg::releaseBundle_t r);
        int idx;
        r = '0;
        for (int i = 0; i < cpuPkg::MACHINE_WIDTH; i++) begin
            if ((pool.size() > 0) && (($urandom % 100) < rate)) begin
                idx = int'($urandom % pool.size());
                r[i].valid = 1'b1;
                r[i].preg = pool[idx];
                pool.delete(idx);
            end
        end
    endtask

    // Lanes are renamed one after another against a running map
    task automatic modelRename(input renamePkg::decodeBundle_t b,
                               output renamePkg::renamedBundle_t expected,
                               output logic stallOut);
        int   allocs;
        logic anyValid;
        allocs = 0;
        anyValid = 1'b0;
        for (int i = 0; i < cpuPkg::MACHINE_WIDTH; i++) begin
            anyValid = anyValid | b[i].valid;
            if (b[i].valid && (b[i].dst != 0)) begin
                allocs++;
            end
        end
        stallOut = anyValid && (freeQ.size() < allocs);
        expected = '0;
        if (!stallOut) begin
            for (int i = 0; i < cpuPkg::MACHINE_WIDTH; i++) begin
                if (b[i].valid) begin
                    expected[i].valid = 1'b1;
                    expected[i].psrc1 = modelMap[b[i].src1];
                    expected[i].psrc2 = modelMap[b[i].src2];
                    expected[i].oldPdst = modelMap[b[i].dst];
                    if (b[i].dst != 0) begin
                        expected[i].pdst = freeQ.pop_front();
                        modelMap[b[i].dst] = expected[i].pdst;
                    end
                    expected[i].src1 = b[i].src1;
                    expected[i].src2 = b[i].src2;
                    expected[i].dst = b[i].dst;
                    expected[i].ctl = b[i].ctl;
                    expected[i].imm = b[i].imm;
                    expected[i].pcplus8 = b[i].pcplus8;
                    expected[i].exception = b[i].exception;
                end
            end
        end
    endtask

    task automatic modelRelease(input renamePkg::releaseBundle_t r);
        for (int i = 0; i < cpuPkg::MACHINE_WIDTH; i++) begin
            if (r[i].valid) begin
                freeQ.push_back(r[i].preg);
            end
        end
    endtask

    // Old mappings of writing lanes become candidates for release
    task automatic recordOldPdsts(input renamePkg::renamedBundle_t seen);
        for (int i = 0; i < cpuPkg::MACHINE_WIDTH; i++) begin
            if (seen[i].valid && (seen[i].dst != 0)) begin
                pool.push_back(seen[i].oldPdst);
            end
        end
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            failRun("Timeout: the test did not finish within the cycle limit");
        end
    end

    initial begin
        seedDummy = $urandom(SEED);
        cycleCount = 0;
        reset = 1'b1;
        inBundle = '0;
        releases = '0;
        for (int a = 0; a < cpuPkg::AREG_COUNT; a++) begin
            modelMap[a] = cpuPkg::pregAddr_t'(a);
        end
        for (int p = cpuPkg::AREG_COUNT; p < cpuPkg::PREG_COUNT; p++) begin
            freeQ.push_back(cpuPkg::pregAddr_t'(p));
        end
        expOut = '0;
        heldStall = 1'b0;
        stallCount = 0;
        curBundle = '0;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            checkBundle(outBundle, expOut);
            recordOldPdsts(expOut);
            // A stalled bundle is held by upstream
            if (!heldStall) begin
                makeBundle(curBundle);
            end
            makeReleases(releaseRate(cyc), curReleases);
            inBundle = curBundle;
            releases = curReleases;
            modelRename(curBundle, nextOut, expStall);
            modelRelease(curReleases);
            #1;
            checkStall(stall, expStall);
            if (expStall) begin
                stallCount++;
            end
            heldStall = expStall;
            expOut = nextOut;
            @(negedge clk);
        end
        checkBundle(outBundle, expOut);

        if (stallCount > 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            failRun("The free list never ran short, so no stall was exercised");
        end
    end

endmodule

`default_nettype wire
